// File: bench/reg_file_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file unit testbench
// Command table, req/ack driver,
// compare tasks and run limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module reg_file_unit_tb;

  import wrf_pkg::*;

  // One command and the state it should leave
  typedef struct packed {
    wrf_op_t   op;
    wrf_addr_t laa;
    wrf_addr_t lba;
    wrf_word_t imm;
    wrf_word_t nlca;
    wrf_word_t exp_result;
    wrf_word_t exp_pr;
    wrf_word_t exp_br;
    wrf_word_t exp_xr;
  } cmd_entry_t;

  logic      aluclk;
  logic      reset;
  logic      req;
  wrf_op_t   op;
  wrf_addr_t laa;
  wrf_addr_t lba;
  wrf_word_t imm;
  wrf_word_t nlca;
  logic      ack;
  wrf_word_t result;
  wrf_word_t pr;
  wrf_word_t br;
  wrf_word_t xr;

  cmd_entry_t cmd_table[$];
  int         cycle_count = 0;
  int         cycle_limit = 0;

  reg_file_unit i_reg_file_unit (
    .aluclk (aluclk),
    .reset  (reset),
    .req    (req),
    .op     (op),
    .laa    (laa),
    .lba    (lba),
    .imm    (imm),
    .nlca   (nlca),
    .ack    (ack),
    .result (result),
    .pr     (pr),
    .br     (br),
    .xr     (xr)
  );

  // 20 ns clock period
  always #10 aluclk = ~aluclk;

  task automatic report_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Run limit, armed once the table length is known
  always @(posedge aluclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, a command handshake did not finish", cycle_count);
      report_failure();
    end
  end

  task automatic check_word(input string name, input wrf_word_t got, input wrf_word_t expected);
    if (got !== expected) begin
      $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, got, expected);
      report_failure();
    end
  endtask

  task automatic check_ack(input logic got, input logic expected);
    if (got !== expected) begin
      $display("[FAIL] time %0t: ack is %b, expected %b", $time, got, expected);
      report_failure();
    end
  endtask

  // Result and the three dedicated registers
  task automatic check_outputs(input cmd_entry_t e);
    check_word("result", result, e.exp_result);
    check_word("pr", pr, e.exp_pr);
    check_word("br", br, e.exp_br);
    check_word("xr", xr, e.exp_xr);
  endtask

  task automatic add_entry(input wrf_op_t e_op, input wrf_addr_t e_laa, input wrf_addr_t e_lba,
                           input wrf_word_t e_imm, input wrf_word_t e_nlca,
                           input wrf_word_t e_res, input wrf_word_t e_pr,
                           input wrf_word_t e_br, input wrf_word_t e_xr);
    cmd_entry_t entry;
    entry = '{e_op, e_laa, e_lba, e_imm, e_nlca, e_res, e_pr, e_br, e_xr};
    cmd_table.push_back(entry);
  endtask

  // Columns: op, laa, lba, imm, nlca, then expected result, pr, br, xr
  task automatic build_table();
    // Load every register, P at 2, B at 3, X at 7
    add_entry(OP_LDI, 4'h0, 4'h0, 16'h0001, 16'h0000, 16'h0001, 16'h0000, 16'h0000, 16'h0000);
    add_entry(OP_LDI, 4'h0, 4'h1, 16'h0010, 16'h0000, 16'h0010, 16'h0000, 16'h0000, 16'h0000);
    add_entry(OP_LDI, 4'h0, 4'h2, 16'h0102, 16'h0000, 16'h0102, 16'h0102, 16'h0000, 16'h0000);
    add_entry(OP_LDI, 4'h0, 4'h3, 16'h1234, 16'h0000, 16'h1234, 16'h0102, 16'h1234, 16'h0000);
    add_entry(OP_LDI, 4'h0, 4'h4, 16'h00ff, 16'h0000, 16'h00ff, 16'h0102, 16'h1234, 16'h0000);
    add_entry(OP_LDI, 4'h0, 4'h5, 16'hff00, 16'h0000, 16'hff00, 16'h0102, 16'h1234, 16'h0000);
    add_entry(OP_LDI, 4'h0, 4'h6, 16'h8000, 16'h0000, 16'h8000, 16'h0102, 16'h1234, 16'h0000);
    add_entry(OP_LDI, 4'h0, 4'h7, 16'h7fff, 16'h0000, 16'h7fff, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_LDI, 4'h0, 4'h8, 16'h0008, 16'h0000, 16'h0008, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_LDI, 4'h0, 4'h9, 16'h0900, 16'h0000, 16'h0900, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_LDI, 4'h0, 4'ha, 16'h00a0, 16'h0000, 16'h00a0, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_LDI, 4'h0, 4'hb, 16'hb00b, 16'h0000, 16'hb00b, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_LDI, 4'h0, 4'hc, 16'hc0de, 16'h0000, 16'hc0de, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_LDI, 4'h0, 4'hd, 16'hdead, 16'h0000, 16'hdead, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_LDI, 4'h0, 4'he, 16'hbeef, 16'h0000, 16'hbeef, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_LDI, 4'h0, 4'hf, 16'hffff, 16'h0000, 16'hffff, 16'h0102, 16'h1234, 16'h7fff);
    // Read back through the A port, both decoder halves
    add_entry(OP_MOV, 4'h0, 4'h0, 16'h0000, 16'h0000, 16'h0001, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'h1, 4'h1, 16'h0000, 16'h0000, 16'h0010, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'h2, 4'h2, 16'h0000, 16'h0000, 16'h0102, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'h3, 4'h3, 16'h0000, 16'h0000, 16'h1234, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'h4, 4'h4, 16'h0000, 16'h0000, 16'h00ff, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'h5, 4'h5, 16'h0000, 16'h0000, 16'hff00, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'h6, 4'h6, 16'h0000, 16'h0000, 16'h8000, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'h7, 4'h7, 16'h0000, 16'h0000, 16'h7fff, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'h8, 4'h8, 16'h0000, 16'h0000, 16'h0008, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'h9, 4'h9, 16'h0000, 16'h0000, 16'h0900, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'ha, 4'ha, 16'h0000, 16'h0000, 16'h00a0, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'hb, 4'hb, 16'h0000, 16'h0000, 16'hb00b, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'hc, 4'hc, 16'h0000, 16'h0000, 16'hc0de, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'hd, 4'hd, 16'h0000, 16'h0000, 16'hdead, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'he, 4'he, 16'h0000, 16'h0000, 16'hbeef, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_MOV, 4'hf, 4'hf, 16'h0000, 16'h0000, 16'hffff, 16'h0102, 16'h1234, 16'h7fff);
    // ALU ops, r1 = 0x11 then 1 - 0x11 wraps below zero
    add_entry(OP_ADD, 4'h0, 4'h1, 16'h0000, 16'h0000, 16'h0011, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_SUB, 4'h0, 4'h1, 16'h0000, 16'h0000, 16'hfff0, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_AND, 4'hc, 4'h5, 16'h0000, 16'h0000, 16'hc000, 16'h0102, 16'h1234, 16'h7fff);
    add_entry(OP_OR,  4'h6, 4'h9, 16'h0000, 16'h0000, 16'h8900, 16'h0102, 16'h1234, 16'h7fff);
    // Results into B and X show up on br and xr
    add_entry(OP_ADD, 4'h3, 4'h3, 16'h0000, 16'h0000, 16'h2468, 16'h0102, 16'h2468, 16'h7fff);
    add_entry(OP_XOR, 4'ha, 4'h7, 16'h0000, 16'h0000, 16'h7f5f, 16'h0102, 16'h2468, 16'h7f5f);
    // Fetch loads P only, B at lba stays put
    add_entry(OP_FETCH, 4'h0, 4'h3, 16'h0000, 16'h4321, 16'h4321, 16'h4321, 16'h2468, 16'h7f5f);
    add_entry(OP_MOV, 4'h2, 4'h2, 16'h0000, 16'h0000, 16'h4321, 16'h4321, 16'h2468, 16'h7f5f);
    // SUB, AND and OR targets copied out via A into other registers
    add_entry(OP_MOV, 4'h1, 4'h4, 16'h0000, 16'h0000, 16'hfff0, 16'h4321, 16'h2468, 16'h7f5f);
    add_entry(OP_MOV, 4'h5, 4'h8, 16'h0000, 16'h0000, 16'hc000, 16'h4321, 16'h2468, 16'h7f5f);
    add_entry(OP_MOV, 4'h9, 4'ha, 16'h0000, 16'h0000, 16'h8900, 16'h4321, 16'h2468, 16'h7f5f);
    // Sum carries past 16 bits and wraps
    add_entry(OP_ADD, 4'hf, 4'h1, 16'h0000, 16'h0000, 16'hffef, 16'h4321, 16'h2468, 16'h7f5f);
  endtask

  // Full four-phase cycle for one table entry
  task automatic run_command(input cmd_entry_t e);
    int hold_cycles;
    op   = e.op;
    laa  = e.laa;
    lba  = e.lba;
    imm  = e.imm;
    nlca = e.nlca;
    req  = 1'b1;
    // Read, execute and write before ack
    repeat (3) begin
      @(negedge aluclk);
      check_ack(ack, 1'b0);
    end
    @(negedge aluclk);
    check_ack(ack, 1'b1);
    check_outputs(e);
    // Requester stalls, ack and state must hold
    hold_cycles = $urandom % 4;
    repeat (hold_cycles) begin
      @(negedge aluclk);
      check_ack(ack, 1'b1);
      check_outputs(e);
    end
    // Drop req, scramble inputs, no second write expected
    req  = 1'b0;
    op   = wrf_op_t'($urandom);
    laa  = wrf_addr_t'($urandom);
    lba  = wrf_addr_t'($urandom);
    imm  = wrf_word_t'($urandom);
    nlca = wrf_word_t'($urandom);
    @(negedge aluclk);
    check_ack(ack, 1'b0);
    check_outputs(e);
  endtask

  initial begin
    void'($urandom(5));
    aluclk = 1'b0;
    reset  = 1'b1;
    req    = 1'b0;
    op     = OP_LDI;
    laa    = '0;
    lba    = '0;
    imm    = '0;
    nlca   = '0;
    build_table();
    cycle_limit = cmd_table.size() * 12 + 50;
    // Three reset cycles, released on a falling edge
    repeat (3) @(negedge aluclk);
    reset = 1'b0;
    check_ack(ack, 1'b0);
    check_word("result", result, '0);
    check_word("pr", pr, '0);
    check_word("br", br, '0);
    check_word("xr", xr, '0);
    for (int i = 0; i < cmd_table.size(); i++) begin
      run_command(cmd_table[i]);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: reg_file_unit.f
+incdir+rtl
rtl/wrf_pkg.sv
rtl/wrf_addr_decode.sv
rtl/wrf_reg_block.sv
rtl/wrf_alu_stage.sv
rtl/wrf_sequencer.sv
rtl/reg_file_unit.sv
bench/reg_file_unit_tb.sv

// File: rtl/reg_file_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file unit top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module reg_file_unit (
  input  logic               aluclk,
  input  logic               reset,
  input  logic               req,
  input  wrf_pkg::wrf_op_t   op,
  input  wrf_pkg::wrf_addr_t laa,
  input  wrf_pkg::wrf_addr_t lba,
  input  wrf_pkg::wrf_word_t imm,
  input  wrf_pkg::wrf_word_t nlca,
  output logic               ack,
  output wrf_pkg::wrf_word_t result,
  output wrf_pkg::wrf_word_t pr,
  output wrf_pkg::wrf_word_t br,
  output wrf_pkg::wrf_word_t xr
);

  import wrf_pkg::*;

  // Sequencer controls
  logic rd_en;
  logic bdest;
  logic xfetch;

  // Decoded selects and write strobes
  wrf_sel_t ea;
  wrf_sel_t eb;
  wrf_sel_t wr;

  // Read ports and write-back value
  wrf_word_t a_data;
  wrf_word_t b_data;
  wrf_word_t wb_data;

  wrf_sequencer i_sequencer (
    .aluclk (aluclk),
    .reset  (reset),
    .req    (req),
    .op     (op),
    .ack    (ack),
    .rd_en  (rd_en),
    .bdest  (bdest),
    .xfetch (xfetch)
  );

  wrf_addr_decode i_addr_decode (
    .laa   (laa),
    .lba   (lba),
    .bdest (bdest),
    .ea    (ea),
    .eb    (eb),
    .wr    (wr)
  );

  wrf_reg_block i_reg_block (
    .aluclk  (aluclk),
    .reset   (reset),
    .ea      (ea),
    .eb      (eb),
    .wr      (wr),
    .wb_data (wb_data),
    .xfetch  (xfetch),
    .nlca    (nlca),
    .a_data  (a_data),
    .b_data  (b_data),
    .pr      (pr),
    .br      (br),
    .xr      (xr)
  );

  wrf_alu_stage i_alu_stage (
    .aluclk  (aluclk),
    .reset   (reset),
    .rd_en   (rd_en),
    .op      (op),
    .a_data  (a_data),
    .b_data  (b_data),
    .imm     (imm),
    .nlca    (nlca),
    .wb_data (wb_data)
  );

  // Write-back value doubles as the command result
  assign result = wb_data;

endmodule

// File: rtl/wrf_addr_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// A/B address decoders and
// write strobe gating
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "wrf_cfg.svh"

module wrf_addr_decode (
  input  wrf_pkg::wrf_addr_t laa,
  input  wrf_pkg::wrf_addr_t lba,
  input  logic               bdest,
  output wrf_pkg::wrf_sel_t  ea,
  output wrf_pkg::wrf_sel_t  eb,
  output wrf_pkg::wrf_sel_t  wr
);

  import wrf_pkg::*;

  // 3-to-8 decoder with enable, one per half of the file
  function automatic logic [7:0] dec_3to8(input logic [2:0] sel, input logic en);
    logic [7:0] hot;
    hot      = '0;
    hot[sel] = en;
    return hot;
  endfunction

  // Top address bit picks low (0..7) or high (8..15) decoder
  assign ea = {dec_3to8(laa[2:0], laa[`WRF_ADDR_W-1]),
               dec_3to8(laa[2:0], ~laa[`WRF_ADDR_W-1])};

  assign eb = {dec_3to8(lba[2:0], lba[`WRF_ADDR_W-1]),
               dec_3to8(lba[2:0], ~lba[`WRF_ADDR_W-1])};

  // Write only the B-selected register, and only on destination strobe
  assign wr = eb & {`WRF_REG_CNT{bdest}};

endmodule

// File: rtl/wrf_alu_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered execute stage for
// the write-back value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wrf_alu_stage (
  input  logic               aluclk,
  input  logic               reset,
  input  logic               rd_en,
  input  wrf_pkg::wrf_op_t   op,
  input  wrf_pkg::wrf_word_t a_data,
  input  wrf_pkg::wrf_word_t b_data,
  input  wrf_pkg::wrf_word_t imm,
  input  wrf_pkg::wrf_word_t nlca,
  output wrf_pkg::wrf_word_t wb_data
);

  import wrf_pkg::*;

  // Next write-back value
  wrf_word_t alu_next;

  // Function select, sums wrap at word width
  always_comb begin
    case (op)
      OP_LDI: begin
        alu_next = imm;
      end
      OP_MOV: begin
        alu_next = a_data;
      end
      OP_ADD: begin
        alu_next = a_data + b_data;
      end
      OP_SUB: begin
        alu_next = a_data - b_data;
      end
      OP_AND: begin
        alu_next = a_data & b_data;
      end
      OP_OR: begin
        alu_next = a_data | b_data;
      end
      OP_XOR: begin
        alu_next = a_data ^ b_data;
      end
      // New P passes through so result shows it
      OP_FETCH: begin
        alu_next = nlca;
      end
      default: begin
        alu_next = '0;
      end
    endcase
  end

  // Capture on the read step, hold through write and ack
  always_ff @(posedge aluclk) begin
    if (reset) begin
      wb_data <= '0;
    end else if (rd_en) begin
      wb_data <= alu_next;
    end
  end

endmodule

// File: rtl/wrf_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Working register file sizes
// Dedicated register positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef WRF_CFG_SVH
`define WRF_CFG_SVH

// Datapath word and register count
`define WRF_WORD_W 16
`define WRF_REG_CNT 16
`define WRF_ADDR_W 4

// Command code width
`define WRF_OP_W 3

// Named registers of the machine
`define WRF_P_INDEX 2
`define WRF_B_INDEX 3
`define WRF_X_INDEX 7

`endif

// File: rtl/wrf_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file types and
// command codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "wrf_cfg.svh"

package wrf_pkg;

  // One data word
  typedef logic [`WRF_WORD_W-1:0] wrf_word_t;

  // Register number
  typedef logic [`WRF_ADDR_W-1:0] wrf_addr_t;

  // One-hot select, bit i picks register i
  typedef logic [`WRF_REG_CNT-1:0] wrf_sel_t;

  // Command code
  typedef logic [`WRF_OP_W-1:0] wrf_op_t;

  // Write-back result per command
  localparam wrf_op_t OP_LDI   = 3'd0;  // immediate
  localparam wrf_op_t OP_MOV   = 3'd1;  // register A
  localparam wrf_op_t OP_ADD   = 3'd2;  // A + B, wraps
  localparam wrf_op_t OP_SUB   = 3'd3;  // A - B, wraps
  localparam wrf_op_t OP_AND   = 3'd4;
  localparam wrf_op_t OP_OR    = 3'd5;
  localparam wrf_op_t OP_XOR   = 3'd6;
  // Loads P from next location, no lba write
  localparam wrf_op_t OP_FETCH = 3'd7;

endpackage

// File: rtl/wrf_reg_block.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sixteen working registers,
// A/B read ports, P/B/X taps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "wrf_cfg.svh"

module wrf_reg_block (
  input  logic               aluclk,
  input  logic               reset,
  input  wrf_pkg::wrf_sel_t  ea,
  input  wrf_pkg::wrf_sel_t  eb,
  input  wrf_pkg::wrf_sel_t  wr,
  input  wrf_pkg::wrf_word_t wb_data,
  input  logic               xfetch,
  input  wrf_pkg::wrf_word_t nlca,
  output wrf_pkg::wrf_word_t a_data,
  output wrf_pkg::wrf_word_t b_data,
  output wrf_pkg::wrf_word_t pr,
  output wrf_pkg::wrf_word_t br,
  output wrf_pkg::wrf_word_t xr
);

  import wrf_pkg::*;

  // Register storage
  wrf_word_t regs [`WRF_REG_CNT];

  // Write port
  always_ff @(posedge aluclk) begin
    if (reset) begin
      for (int i = 0; i < `WRF_REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Strobes are one-hot, at most one register loads
      for (int i = 0; i < `WRF_REG_CNT; i++) begin
        if (wr[i]) begin
          regs[i] <= wb_data;
        end
      end
      // Instruction fetch takes P from next location
      if (xfetch) begin
        regs[`WRF_P_INDEX] <= nlca;
      end
    end
  end

  // Read ports, AND-OR mux on the one-hot selects
  always_comb begin
    a_data = '0;
    b_data = '0;
    for (int i = 0; i < `WRF_REG_CNT; i++) begin
      if (ea[i]) begin
        a_data = a_data | regs[i];
      end
      if (eb[i]) begin
        b_data = b_data | regs[i];
      end
    end
  end

  // Dedicated register taps
  assign pr = regs[`WRF_P_INDEX];
  assign br = regs[`WRF_B_INDEX];
  assign xr = regs[`WRF_X_INDEX];

endmodule

// File: rtl/wrf_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase req/ack handler,
// read/execute/write FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wrf_sequencer (
  input  logic             aluclk,
  input  logic             reset,
  input  logic             req,
  input  wrf_pkg::wrf_op_t op,
  output logic             ack,
  output logic             rd_en,
  output logic             bdest,
  output logic             xfetch
);

  import wrf_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE,
    ST_DONE,
    ST_RELEASE
  } seq_state_t;

  seq_state_t state;

  // All control outputs registered
  always_ff @(posedge aluclk) begin
    if (reset) begin
      state  <= ST_IDLE;
      ack    <= 1'b0;
      rd_en  <= 1'b0;
      bdest  <= 1'b0;
      xfetch <= 1'b0;
    end else begin
      case (state)
        // Wait for a new command
        ST_IDLE: begin
          if (req) begin
            state <= ST_READ;
            rd_en <= 1'b1;
          end
        end
        // Operands read, ALU captures at this edge
        ST_READ: begin
          state  <= ST_WRITE;
          rd_en  <= 1'b0;
          bdest  <= (op != OP_FETCH);
          xfetch <= (op == OP_FETCH);
        end
        // Register written at this edge
        ST_WRITE: begin
          state  <= ST_DONE;
          bdest  <= 1'b0;
          xfetch <= 1'b0;
        end
        // Result settled, raise ack
        ST_DONE: begin
          state <= ST_RELEASE;
          ack   <= 1'b1;
        end
        // Hold ack while requester keeps req high
        ST_RELEASE: begin
          if (!req) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the register file unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -Mdir obj_dir \
  --top-module reg_file_unit_tb -f reg_file_unit.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit $build_status
fi

./obj_dir/Vreg_file_unit_tb
run_status=$?
if [ $run_status -ne 0 ]; then
  echo "Simulation failed with status $run_status"
  exit $run_status
fi

echo "Simulation exited cleanly"
exit 0
